// ==== all.f ====
cpu_pkg.sv
mem_ctrl.sv
memory_access.sv
lsu.sv
data_ram.sv
mem_stage_top.sv
mem_stage_assert.sv
tb_mem_stage.sv

// ==== Makefile ====
SIM = verilator
FLAGS = --binary --timing --assert
TOP = tb_mem_stage
FLIST = all.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_mem_stage.sv ====
// Testbench for the memory stage that checks writeback and exceptions against a shadow memory model
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

	localparam int RAM_WORDS = 256;
	localparam int RAM_BYTES = RAM_WORDS * 4;
	localparam int TMO = 200;	// Cycles allowed for any single wait

	typedef struct packed {
		cpu_pkg::wb_t wb;
		logic exc;
		cpu_pkg::exc_code_t code;
		logic [31:0] addr;
	} exp_t;

	logic clk = 1'b0;
	logic nrst;
	cpu_pkg::ex_mem_t i_ex;
	logic i_exec_stall;
	logic i_fetch_stall;
	logic i_exc_ack;
	logic o_stall;
	logic o_advance;
	cpu_pkg::wb_t o_wb;
	logic o_exc_valid;
	cpu_pkg::exc_code_t o_exc_code;
	logic [31:0] o_exc_addr;

	logic [7:0] shadow [RAM_BYTES];	// Byte image of the data RAM
	logic [31:0] rnd = 32'd69;
	bit stall_mode = 1'b0;	// Random external stalls when set
	bit pending = 1'b0;	// Exception waiting for acknowledge
	cpu_pkg::exc_code_t pend_code = cpu_pkg::EXC_ADDR;
	logic [31:0] pend_addr = '0;
	exp_t exp_q;
	int errors = 0;
	int checks = 0;
	event check_ev;

	mem_stage_top #(.ADDR_WIDTH(32), .RAM_WORDS(RAM_WORDS)) u_mem_stage_top (
		.clk(clk), .nrst(nrst), .i_ex(i_ex), .i_exec_stall(i_exec_stall),
		.i_fetch_stall(i_fetch_stall), .i_exc_ack(i_exc_ack), .o_stall(o_stall),
		.o_advance(o_advance), .o_wb(o_wb), .o_exc_valid(o_exc_valid),
		.o_exc_code(o_exc_code), .o_exc_addr(o_exc_addr)
	);

	always #2 clk = ~clk;	// 4 ns period

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic cpu_pkg::ex_mem_t make_ex(logic [4:0] rd, logic [31:0] a,
		cpu_pkg::lsu_op_t op, logic lns, logic ext, logic [31:0] d);
		return '{rd_no: rd, alu_result: a, lsu_op: op, lsu_lns: lns, lsu_ext: ext, mem_data: d};
	endfunction

	// Expected writeback and exception state after one instruction
	function automatic exp_t ref_result(cpu_pkg::ex_mem_t ex);
		exp_t r;
		int size;
		logic [31:0] val;
		logic mis;
		r = '{wb: '{rd_no: ex.rd_no, rd_val: ex.alu_result}, exc: pending, code: pend_code,
			addr: pend_addr};
		if (pending)
		begin
			r.wb.rd_no = '0;	// Squashed while the exception is held
			return r;
		end
		if (ex.lsu_op == cpu_pkg::LSU_IDLE)
			return r;
		size = (ex.lsu_op == cpu_pkg::LSU_BYTE) ? 1 : (ex.lsu_op == cpu_pkg::LSU_HWORD) ? 2 : 4;
		mis = (size == 2 && ex.alu_result[0]) || (size == 4 && ex.alu_result[1:0] != 2'b00);
		if (mis || ex.alu_result >= 32'(RAM_BYTES))
		begin
			r.wb.rd_no = '0;
			r.exc = 1'b1;
			r.code = mis ? cpu_pkg::EXC_ADDR : cpu_pkg::EXC_BUS;
			r.addr = ex.alu_result;
			return r;
		end
		if (ex.lsu_lns)
		begin
			val = '0;
			for (int i = 0; i < size; i++)
				val = val | (32'(shadow[int'(ex.alu_result) + i]) << (8 * i));	// Little endian
			if (size == 1)
				r.wb.rd_val = ex.lsu_ext ? {{24{val[7]}}, val[7:0]} : {24'h0, val[7:0]};
			else if (size == 2)
				r.wb.rd_val = ex.lsu_ext ? {{16{val[15]}}, val[15:0]} : {16'h0, val[15:0]};
			else
				r.wb.rd_val = val;
		end
		return r;
	endfunction

	task automatic abort_run(string what);
		$display("%s at %0t", what, $time);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic drive_stalls();
		rnd = xorshift(rnd);
		i_exec_stall <= stall_mode & rnd[0] & rnd[1];	// About one cycle in four each
		i_fetch_stall <= stall_mode & rnd[2] & rnd[3];
	endtask

	// Issues one instruction, waits for its result and hands it to the checker
	task automatic run_op(cpu_pkg::ex_mem_t ex);
		exp_t e;
		bit accepted;
		bit adv_exp;
		bit mem;
		int n;
		int busy_cycles;
		e = ref_result(ex);
		mem = (ex.lsu_op != cpu_pkg::LSU_IDLE) && !pending;
		i_ex <= ex;
		drive_stalls();
		accepted = 1'b0;
		n = 0;
		while (!accepted)
		begin
			@(negedge clk);
			accepted = o_advance;	// Taken at the coming edge
			adv_exp = !(i_exec_stall || i_fetch_stall);	// Nothing is in flight while waiting
			assert (o_advance == adv_exp)
			else
			begin
				$display("Mismatch at %0t: o_advance expected %b got %b", $time, adv_exp,
					o_advance);
				errors++;
			end
			@(posedge clk);
			drive_stalls();
			if (accepted)
				i_ex <= make_ex(5'd0, 32'd0, cpu_pkg::LSU_IDLE, 1'b0, 1'b0, 32'd0);
			n++;
			if (n > TMO)
				abort_run("Timeout waiting for the stage to accept an instruction");
		end
		@(negedge clk);
		if (mem)
		begin
			assert (o_stall)
			else
			begin
				$display("Stall did not rise after a memory command at %0t", $time);
				errors++;
			end
			busy_cycles = 0;
			n = 0;
			while (o_stall)
			begin
				busy_cycles++;
				@(negedge clk);
				n++;
				if (n > TMO)
					abort_run("Timeout waiting for the memory access to finish");
			end
			if (e.exc && e.code == cpu_pkg::EXC_ADDR)
				assert (busy_cycles == 1)
				else
				begin
					$display("Misaligned access busy for %0d cycles at %0t", busy_cycles, $time);
					errors++;
				end
			else
				assert (busy_cycles >= 3)
				else
				begin
					$display("Memory access finished after only %0d cycles at %0t", busy_cycles,
						$time);
					errors++;
				end
		end
		exp_q = e;
		-> check_ev;
		@(posedge clk);
		drive_stalls();
		if (mem && !e.exc && !ex.lsu_lns)	// Completed store goes into the shadow
			for (int i = 0; i < (ex.lsu_op == cpu_pkg::LSU_BYTE ? 1 :
				ex.lsu_op == cpu_pkg::LSU_HWORD ? 2 : 4); i++)
				shadow[int'(ex.alu_result) + i] = ex.mem_data[8*i +: 8];
		pending = e.exc;
		pend_code = e.code;
		pend_addr = e.addr;
	endtask

	task automatic ack_exception();
		i_exc_ack <= 1'b1;
		@(posedge clk);
		i_exc_ack <= 1'b0;	// Exception clears at this edge
		pending = 1'b0;
	endtask

	// Compares outputs at the result point of each instruction
	always @(check_ev)
	begin
		checks++;
		if (exp_q.wb.rd_no != '0)
			assert (o_wb == exp_q.wb)
			else
			begin
				$display("Mismatch at %0t: o_wb expected %h got %h", $time, exp_q.wb, o_wb);
				errors++;
			end
		else
			assert (o_wb.rd_no == '0)
			else
			begin
				$display("Mismatch at %0t: o_wb.rd_no expected 0 got %0d", $time, o_wb.rd_no);
				errors++;
			end
		assert (o_exc_valid == exp_q.exc)
		else
		begin
			$display("Mismatch at %0t: o_exc_valid expected %b got %b", $time, exp_q.exc,
				o_exc_valid);
			errors++;
		end
		if (exp_q.exc)
			assert (o_exc_code == exp_q.code && o_exc_addr == exp_q.addr)
			else
			begin
				$display("Mismatch at %0t: o_exc_code/o_exc_addr expected %0d/%h got %0d/%h",
					$time, exp_q.code, exp_q.addr, o_exc_code, o_exc_addr);
				errors++;
			end
	end

	task automatic end_test(string name, int errs_before);
		$display("Test %s finished with %0d errors", name, errors - errs_before);
	endtask

	initial
	begin
		int eb;
		logic [31:0] a;
		for (int i = 0; i < RAM_BYTES; i++)
			shadow[i] = 8'h00;	// RAM is cleared by reset
		nrst = 1'b0;
		i_ex = make_ex(5'd0, 32'd0, cpu_pkg::LSU_IDLE, 1'b0, 1'b0, 32'd0);
		i_exec_stall = 1'b0;
		i_fetch_stall = 1'b0;
		i_exc_ack = 1'b0;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		@(posedge clk);

		eb = errors;
		for (int i = 0; i < 8; i++)
		begin
			rnd = xorshift(rnd);
			a = xorshift(rnd);
			run_op(make_ex(5'(rnd[4:0] | 5'd1), a, cpu_pkg::LSU_IDLE, 1'b0, 1'b0, 32'd0));
		end
		end_test("alu_pass", eb);

		eb = errors;
		for (int i = 0; i < 8; i++)
		begin
			rnd = xorshift(rnd);
			a = {22'd0, rnd[7:0], 2'b00};	// Aligned word inside the RAM
			run_op(make_ex(5'd0, a, cpu_pkg::LSU_WORD, 1'b0, 1'b0, xorshift(rnd)));
			run_op(make_ex(5'd3, a, cpu_pkg::LSU_WORD, 1'b1, 1'b0, 32'd0));
		end
		end_test("word_store_load", eb);

		eb = errors;
		run_op(make_ex(5'd0, 32'h40, cpu_pkg::LSU_WORD, 1'b0, 1'b0, 32'h0123_4567));
		for (int off = 0; off < 4; off++)
			run_op(make_ex(5'd0, 32'h40 + 32'(off), cpu_pkg::LSU_BYTE, 1'b0, 1'b0,
				32'h80 + 32'(off * 17)));
		for (int off = 0; off < 4; off += 2)
			run_op(make_ex(5'd0, 32'h50 + 32'(off), cpu_pkg::LSU_HWORD, 1'b0, 1'b0,
				32'h9a00 + 32'(off)));
		for (int off = 0; off < 4; off++)
			for (int ext = 0; ext < 2; ext++)
			begin
				run_op(make_ex(5'd5, 32'h40 + 32'(off), cpu_pkg::LSU_BYTE, 1'b1, 1'(ext), 32'd0));
				if (off % 2 == 0)
					run_op(make_ex(5'd6, 32'h50 + 32'(off), cpu_pkg::LSU_HWORD, 1'b1, 1'(ext),
						32'd0));
			end
		run_op(make_ex(5'd7, 32'h40, cpu_pkg::LSU_WORD, 1'b1, 1'b0, 32'd0));
		run_op(make_ex(5'd7, 32'h50, cpu_pkg::LSU_WORD, 1'b1, 1'b0, 32'd0));
		end_test("sub_word", eb);

		eb = errors;
		run_op(make_ex(5'd0, 32'h41, cpu_pkg::LSU_HWORD, 1'b0, 1'b0, 32'hffff));
		run_op(make_ex(5'd8, 32'h40, cpu_pkg::LSU_WORD, 1'b1, 1'b0, 32'd0));
		run_op(make_ex(5'd9, 32'h1234, cpu_pkg::LSU_IDLE, 1'b0, 1'b0, 32'd0));
		ack_exception();
		run_op(make_ex(5'd8, 32'h40, cpu_pkg::LSU_WORD, 1'b1, 1'b0, 32'd0));
		run_op(make_ex(5'd4, 32'h52, cpu_pkg::LSU_WORD, 1'b1, 1'b0, 32'd0));
		ack_exception();
		end_test("misaligned", eb);

		eb = errors;
		run_op(make_ex(5'd10, 32'(RAM_BYTES), cpu_pkg::LSU_WORD, 1'b1, 1'b0, 32'd0));
		run_op(make_ex(5'd11, 32'h44, cpu_pkg::LSU_WORD, 1'b1, 1'b0, 32'd0));
		ack_exception();
		run_op(make_ex(5'd0, 32'(RAM_BYTES + 8), cpu_pkg::LSU_WORD, 1'b0, 1'b0, 32'h5));
		ack_exception();
		run_op(make_ex(5'd0, 32'h48, cpu_pkg::LSU_WORD, 1'b0, 1'b0, 32'hcafe_f00d));
		run_op(make_ex(5'd12, 32'h48, cpu_pkg::LSU_WORD, 1'b1, 1'b0, 32'd0));
		end_test("out_of_range", eb);

		eb = errors;
		stall_mode = 1'b1;
		for (int i = 0; i < 16; i++)
		begin
			rnd = xorshift(rnd);
			a = {24'd0, rnd[7:1], 1'b0};	// Even address so halfwords stay legal
			run_op(make_ex(5'd0, a, cpu_pkg::LSU_HWORD, 1'b0, 1'b0, xorshift(rnd)));
			run_op(make_ex(5'(i + 1), a, rnd[9] ? cpu_pkg::LSU_HWORD : cpu_pkg::LSU_BYTE, 1'b1,
				rnd[10], 32'd0));
			run_op(make_ex(5'd20, rnd, cpu_pkg::LSU_IDLE, 1'b0, 1'b0, 32'd0));
		end
		stall_mode = 1'b0;
		end_test("external_stall", eb);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mem_stage_assert.sv ====
// Concurrent protocol checks on the LSU, bound into every lsu instance
`timescale 1ns/1ps
`default_nettype none

module mem_stage_assert (
	input wire clk,
	input wire nrst,
	input cpu_pkg::lsu_req_t i_req,
	input cpu_pkg::lsu_rsp_t i_rsp,
	input cpu_pkg::axil_req_t i_axil_req,
	input cpu_pkg::axil_rsp_t i_axil_rsp
);

	logic misalign;

	assign misalign = (i_req.cmd == cpu_pkg::LSU_HWORD && i_req.addr[0]) ||
		(i_req.cmd == cpu_pkg::LSU_WORD && i_req.addr[1:0] != 2'b00);	// Same rule as the ISA

	aw_hold: assert property (@(posedge clk) disable iff (!nrst)
		i_axil_req.awvalid && !i_axil_rsp.awready |=>
		i_axil_req.awvalid && $stable(i_axil_req.awaddr))
		else $error("AW dropped or changed before AWREADY");
	w_hold: assert property (@(posedge clk) disable iff (!nrst)
		i_axil_req.wvalid && !i_axil_rsp.wready |=>
		i_axil_req.wvalid && $stable(i_axil_req.wdata) && $stable(i_axil_req.wstrb))
		else $error("W dropped or changed before WREADY");
	ar_hold: assert property (@(posedge clk) disable iff (!nrst)
		i_axil_req.arvalid && !i_axil_rsp.arready |=>
		i_axil_req.arvalid && $stable(i_axil_req.araddr))
		else $error("AR dropped or changed before ARREADY");
	// A legal command keeps busy high past its own cycle while the transfer runs
	busy_on_cmd: assert property (@(posedge clk) disable iff (!nrst)
		i_req.cmd != cpu_pkg::LSU_IDLE && !misalign |=> i_rsp.busy)
		else $error("Busy dropped right after a legal command");
	no_bus_on_misalign: assert property (@(posedge clk) disable iff (!nrst)
		misalign |=> !i_axil_req.arvalid && !i_axil_req.awvalid)
		else $error("Bus transfer started for a misaligned command");

endmodule

bind lsu mem_stage_assert u_mem_stage_assert (
	.clk(clk),
	.nrst(nrst),
	.i_req(i_req),
	.i_rsp(o_rsp),
	.i_axil_req(o_axil),
	.i_axil_rsp(i_axil)
);

`default_nettype wire

// ==== mem_stage_top.sv ====
// Top level of the memory stage tying control, stage, LSU and data memory together
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top #(
	parameter int ADDR_WIDTH = 32,
	parameter int RAM_WORDS = 256
) (
	input wire clk,
	input wire nrst,
	input cpu_pkg::ex_mem_t i_ex,
	input wire i_exec_stall,
	input wire i_fetch_stall,
	input wire i_exc_ack,
	output logic o_stall,
	output logic o_advance,
	output cpu_pkg::wb_t o_wb,
	output logic o_exc_valid,
	output cpu_pkg::exc_code_t o_exc_code,
	output logic [cpu_pkg::DATA_WIDTH-1:0] o_exc_addr
);

	cpu_pkg::lsu_req_t lsu_req;
	cpu_pkg::lsu_rsp_t lsu_rsp;
	cpu_pkg::axil_req_t axil_req;
	cpu_pkg::axil_rsp_t axil_rsp;
	logic nullify;
	logic bus_error;
	logic addr_error;
	logic [cpu_pkg::DATA_WIDTH-1:0] fault_addr;

	mem_ctrl u_mem_ctrl (
		.clk(clk),
		.nrst(nrst),
		.i_exec_stall(i_exec_stall),
		.i_fetch_stall(i_fetch_stall),
		.i_busy(lsu_rsp.busy),
		.i_bus_error(bus_error),
		.i_addr_error(addr_error),
		.i_fault_addr(fault_addr),
		.i_exc_ack(i_exc_ack),
		.o_advance(o_advance),
		.o_nullify(nullify),
		.o_stall(o_stall),
		.o_exc_valid(o_exc_valid),
		.o_exc_code(o_exc_code),
		.o_exc_addr(o_exc_addr)
	);

	memory_access u_memory_access (
		.clk(clk),
		.nrst(nrst),
		.i_advance(o_advance),
		.i_nullify(nullify),
		.i_ex(i_ex),
		.o_lsu_req(lsu_req),
		.i_lsu_rsp(lsu_rsp),
		.o_bus_error(bus_error),
		.o_addr_error(addr_error),
		.o_fault_addr(fault_addr),
		.o_wb(o_wb)
	);

	lsu #(.ADDR_WIDTH(ADDR_WIDTH)) u_lsu (
		.clk(clk),
		.nrst(nrst),
		.i_req(lsu_req),
		.o_rsp(lsu_rsp),
		.o_axil(axil_req),
		.i_axil(axil_rsp)
	);

	data_ram #(.ADDR_WIDTH(ADDR_WIDTH), .RAM_WORDS(RAM_WORDS)) u_data_ram (
		.clk(clk),
		.nrst(nrst),
		.i_axil(axil_req),
		.o_axil(axil_rsp)
	);

endmodule

`default_nettype wire

// ==== data_ram.sv ====
// AXI4-Lite word memory with byte strobes that answers SLVERR outside its depth
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
	parameter int ADDR_WIDTH = 32,
	parameter int RAM_WORDS = 256
) (
	input wire clk,
	input wire nrst,
	input cpu_pkg::axil_req_t i_axil,
	output cpu_pkg::axil_rsp_t o_axil
);

	localparam int DW = cpu_pkg::DATA_WIDTH;
	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam int RAM_BYTES = RAM_WORDS * 4;

	logic [DW-1:0] mem [RAM_WORDS];
	logic [ADDR_WIDTH-1:0] waddr;
	logic [ADDR_WIDTH-1:0] raddr;
	logic wr_acc;	// AW and W taken in the same cycle
	logic rd_acc;
	logic bvalid_q;
	logic [1:0] bresp_q;
	logic rvalid_q;
	logic [1:0] rresp_q;
	logic [DW-1:0] rdata_q;

	assign waddr = i_axil.awaddr[ADDR_WIDTH-1:0];
	assign raddr = i_axil.araddr[ADDR_WIDTH-1:0];
	assign wr_acc = i_axil.awvalid && i_axil.wvalid && !bvalid_q;
	assign rd_acc = i_axil.arvalid && !rvalid_q;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < RAM_WORDS; i++)
				mem[i] <= '0;
			bvalid_q <= 1'b0;
			bresp_q <= cpu_pkg::RESP_OKAY;
			rvalid_q <= 1'b0;
			rresp_q <= cpu_pkg::RESP_OKAY;
			rdata_q <= '0;
		end
		else
		begin
			if (wr_acc)
			begin
				bvalid_q <= 1'b1;	// Response one cycle after acceptance
				bresp_q <= (waddr < RAM_BYTES) ? cpu_pkg::RESP_OKAY : cpu_pkg::RESP_SLVERR;
				if (waddr < RAM_BYTES)
					for (int b = 0; b < DW / 8; b++)
						if (i_axil.wstrb[b])
							mem[waddr[IDX_W+1:2]][8*b +: 8] <= i_axil.wdata[8*b +: 8];
			end
			else if (i_axil.bready)
				bvalid_q <= 1'b0;
			if (rd_acc)
			begin
				rvalid_q <= 1'b1;
				rresp_q <= (raddr < RAM_BYTES) ? cpu_pkg::RESP_OKAY : cpu_pkg::RESP_SLVERR;
				rdata_q <= (raddr < RAM_BYTES) ? mem[raddr[IDX_W+1:2]] : '0;	// Zero when out of range
			end
			else if (i_axil.rready)
				rvalid_q <= 1'b0;
		end
	end

	assign o_axil = '{
		awready: wr_acc,
		wready: wr_acc,
		bvalid: bvalid_q,
		bresp: bresp_q,
		arready: !rvalid_q,
		rvalid: rvalid_q,
		rdata: rdata_q,
		rresp: rresp_q
	};

endmodule

`default_nettype wire

// ==== lsu.sv ====
// Load/store unit turning one-cycle LSU commands into single AXI4-Lite transfers
`timescale 1ns/1ps
`default_nettype none

module lsu #(
	parameter int ADDR_WIDTH = 32
) (
	input wire clk,
	input wire nrst,
	input cpu_pkg::lsu_req_t i_req,
	output cpu_pkg::lsu_rsp_t o_rsp,
	output cpu_pkg::axil_req_t o_axil,
	input cpu_pkg::axil_rsp_t i_axil
);

	localparam int DW = cpu_pkg::DATA_WIDTH;

	typedef enum logic [2:0] {
		S_IDLE,		// Waiting for a command
		S_WADDR,	// AW and W raised together
		S_WRESP,	// Waiting for B
		S_RADDR,	// AR raised
		S_RDATA		// Waiting for R
	} state_t;

	state_t state;
	logic cmd_vld;
	logic misalign;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [DW-1:0] wdata_q;
	logic [DW/8-1:0] wstrb_q;
	logic [DW-1:0] rdata_q;
	logic [DW/8-1:0] wstrb;
	logic [DW-1:0] wdata;

	assign cmd_vld = (i_req.cmd != cpu_pkg::LSU_IDLE);
	assign misalign = cmd_vld && ((i_req.cmd == cpu_pkg::LSU_HWORD && i_req.addr[0]) ||
		(i_req.cmd == cpu_pkg::LSU_WORD && i_req.addr[1:0] != 2'b00));

	// Byte lanes and replicated store data from the address offset
	always_comb
	begin
		case (i_req.cmd)
		cpu_pkg::LSU_BYTE:
		begin
			wstrb = 4'b0001 << i_req.addr[1:0];
			wdata = {4{i_req.wdata[7:0]}};
		end
		cpu_pkg::LSU_HWORD:
		begin
			wstrb = 4'b0011 << i_req.addr[1:0];
			wdata = {2{i_req.wdata[15:0]}};
		end
		default:
		begin
			wstrb = 4'b1111;
			wdata = i_req.wdata;
		end
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			state <= S_IDLE;
		else
		begin
			case (state)
			S_IDLE: if (cmd_vld && !misalign) state <= i_req.rnw ? S_RADDR : S_WADDR;
			S_WADDR: if (i_axil.awready && i_axil.wready) state <= S_WRESP;
			S_WRESP: if (i_axil.bvalid) state <= S_IDLE;
			S_RADDR: if (i_axil.arready) state <= S_RDATA;
			S_RDATA: if (i_axil.rvalid) state <= S_IDLE;
			default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && cmd_vld)
		begin
			addr_q <= i_req.addr[ADDR_WIDTH-1:0];
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
		if (state == S_RDATA && i_axil.rvalid)
			rdata_q <= i_axil.rdata >> {addr_q[1:0], 3'b000};	// Addressed bytes to bit 0
	end

	assign o_axil = '{
		awvalid: (state == S_WADDR),
		awaddr: DW'(addr_q),
		wvalid: (state == S_WADDR),
		wdata: wdata_q,
		wstrb: wstrb_q,
		bready: (state == S_WRESP),
		arvalid: (state == S_RADDR),
		araddr: DW'(addr_q),
		rready: (state == S_RDATA)
	};

	// Busy covers the command cycle itself, so a misaligned access is busy for one cycle
	assign o_rsp = '{
		rdata: rdata_q,
		busy: cmd_vld || (state != S_IDLE),
		err_align: misalign,
		err_bus: (state == S_WRESP && i_axil.bvalid && i_axil.bresp == cpu_pkg::RESP_SLVERR) ||
			(state == S_RDATA && i_axil.rvalid && i_axil.rresp == cpu_pkg::RESP_SLVERR)
	};

endmodule

`default_nettype wire

// ==== memory_access.sv ====
// Memory stage register that issues LSU commands and extends load data for writeback
`timescale 1ns/1ps
`default_nettype none

module memory_access (
	input wire clk,
	input wire nrst,
	input wire i_advance,				// Stage may take the next instruction
	input wire i_nullify,				// Exception pending, squash what is taken
	input cpu_pkg::ex_mem_t i_ex,
	output cpu_pkg::lsu_req_t o_lsu_req,
	input cpu_pkg::lsu_rsp_t i_lsu_rsp,
	output logic o_bus_error,
	output logic o_addr_error,
	output logic [cpu_pkg::DATA_WIDTH-1:0] o_fault_addr,
	output cpu_pkg::wb_t o_wb
);

	// Selects what goes to the destination register
	typedef enum logic [2:0] {
		MUX_ALU,		// ALU result
		MUX_BYTE_SE,	// Sign-extended byte
		MUX_BYTE_ZE,	// Zero-extended byte
		MUX_HWORD_SE,	// Sign-extended halfword
		MUX_HWORD_ZE,	// Zero-extended halfword
		MUX_WORD		// Whole word
	} rd_mux_t;

	localparam int DW = cpu_pkg::DATA_WIDTH;

	cpu_pkg::lsu_op_t cmd_q;
	logic rnw_q;
	logic [DW-1:0] addr_q;
	logic [DW-1:0] wdata_q;
	logic [DW-1:0] alu_q;
	logic [cpu_pkg::REGNO_WIDTH-1:0] rd_no_q;
	rd_mux_t mux_q;
	logic err_bus_q;	// Sticky until the next advance
	logic err_align_q;
	logic [DW-1:0] rdata;

	assign o_lsu_req = '{addr: addr_q, wdata: wdata_q, cmd: cmd_q, rnw: rnw_q};
	assign o_bus_error = i_lsu_rsp.err_bus | err_bus_q;
	assign o_addr_error = i_lsu_rsp.err_align | err_align_q;
	assign o_fault_addr = addr_q;	// Still holds the address of the failing access
	assign rdata = i_lsu_rsp.rdata;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			cmd_q <= cpu_pkg::LSU_IDLE;
			rnw_q <= 1'b0;
			rd_no_q <= '0;
			mux_q <= MUX_ALU;
			err_bus_q <= 1'b0;
			err_align_q <= 1'b0;
		end
		else
		begin
			cmd_q <= cpu_pkg::LSU_IDLE;	// Command is a single-cycle pulse
			err_bus_q <= err_bus_q | i_lsu_rsp.err_bus;
			err_align_q <= err_align_q | i_lsu_rsp.err_align;
			if (i_advance)
			begin
				rd_no_q <= i_nullify ? '0 : i_ex.rd_no;
				cmd_q <= i_nullify ? cpu_pkg::LSU_IDLE : i_ex.lsu_op;
				rnw_q <= i_ex.lsu_lns;
				err_bus_q <= 1'b0;
				err_align_q <= 1'b0;
				case (i_ex.lsu_op)
				cpu_pkg::LSU_BYTE: mux_q <= i_ex.lsu_ext ? MUX_BYTE_SE : MUX_BYTE_ZE;
				cpu_pkg::LSU_HWORD: mux_q <= i_ex.lsu_ext ? MUX_HWORD_SE : MUX_HWORD_ZE;
				cpu_pkg::LSU_WORD: mux_q <= MUX_WORD;
				default: mux_q <= MUX_ALU;
				endcase
			end
			else if (i_lsu_rsp.err_bus || i_lsu_rsp.err_align)
				rd_no_q <= '0;	// A faulting access writes nothing back
		end
	end

	// Payload follows the stage advance
	always_ff @(posedge clk)
	begin
		if (i_advance)
		begin
			addr_q <= i_ex.alu_result;
			wdata_q <= i_ex.mem_data;
			alu_q <= i_ex.alu_result;
		end
	end

	always_comb
	begin
		o_wb.rd_no = rd_no_q;
		case (mux_q)
		MUX_BYTE_SE: o_wb.rd_val = {{(DW-8){rdata[7]}}, rdata[7:0]};
		MUX_BYTE_ZE: o_wb.rd_val = {{(DW-8){1'b0}}, rdata[7:0]};
		MUX_HWORD_SE: o_wb.rd_val = {{(DW-16){rdata[15]}}, rdata[15:0]};
		MUX_HWORD_ZE: o_wb.rd_val = {{(DW-16){1'b0}}, rdata[15:0]};
		MUX_WORD: o_wb.rd_val = rdata;
		default: o_wb.rd_val = alu_q;
		endcase
	end

endmodule

`default_nettype wire

// ==== mem_ctrl.sv ====
// Stage control that combines stalls into advance and holds the exception until acknowledged
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
	input wire clk,
	input wire nrst,
	input wire i_exec_stall,
	input wire i_fetch_stall,
	input wire i_busy,			// LSU transfer in progress
	input wire i_bus_error,
	input wire i_addr_error,
	input wire [cpu_pkg::DATA_WIDTH-1:0] i_fault_addr,
	input wire i_exc_ack,
	output logic o_advance,
	output logic o_nullify,
	output logic o_stall,
	output logic o_exc_valid,
	output cpu_pkg::exc_code_t o_exc_code,
	output logic [cpu_pkg::DATA_WIDTH-1:0] o_exc_addr
);

	logic err;
	logic err_q;	// Error level one cycle back
	logic err_new;

	assign err = i_bus_error || i_addr_error;
	// The error flags stay high until the next advance, so only their rise counts
	assign err_new = err && !err_q;

	assign o_stall = i_busy;
	assign o_advance = !(i_exec_stall || i_fetch_stall || i_busy);
	assign o_nullify = o_exc_valid;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			err_q <= 1'b0;
			o_exc_valid <= 1'b0;
			o_exc_code <= cpu_pkg::EXC_ADDR;
			o_exc_addr <= '0;
		end
		else
		begin
			err_q <= err;
			if (i_exc_ack)
				o_exc_valid <= 1'b0;
			if (err_new && !o_exc_valid)
			begin
				o_exc_valid <= 1'b1;	// First error wins until acknowledged
				o_exc_code <= i_bus_error ? cpu_pkg::EXC_BUS : cpu_pkg::EXC_ADDR;
				o_exc_addr <= i_fault_addr;
			end
		end
	end

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
// Shared widths, LSU codes, stage structs and AXI4-Lite channel structs for the memory stage
`default_nettype none

package cpu_pkg;

	localparam int DATA_WIDTH = 32;	// Word and register width
	localparam int REGNO_WIDTH = 5;	// Register number width

	localparam logic [1:0] RESP_OKAY = 2'b00;	// Normal completion
	localparam logic [1:0] RESP_SLVERR = 2'b10;	// Slave error, used for out-of-range addresses

	typedef enum logic [1:0] {
		LSU_IDLE = 2'd0,	// No transfer
		LSU_BYTE = 2'd1,	// 8-bit access
		LSU_HWORD = 2'd2,	// 16-bit access, even address only
		LSU_WORD = 2'd3		// 32-bit access, word aligned only
	} lsu_op_t;

	typedef enum logic {
		EXC_ADDR = 1'b0,	// Misaligned access
		EXC_BUS = 1'b1		// Bus answered with SLVERR
	} exc_code_t;

	typedef struct packed {
		logic [REGNO_WIDTH-1:0] rd_no;		// Destination register, zero means no write
		logic [DATA_WIDTH-1:0] alu_result;	// ALU result, doubles as the memory address
		lsu_op_t lsu_op;					// Access size or idle
		logic lsu_lns;						// 1 for load, 0 for store
		logic lsu_ext;						// 1 to sign-extend a load
		logic [DATA_WIDTH-1:0] mem_data;	// Store data, right aligned
	} ex_mem_t;

	typedef struct packed {
		logic [REGNO_WIDTH-1:0] rd_no;	// Zero means nothing is written back
		logic [DATA_WIDTH-1:0] rd_val;
	} wb_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] addr;	// Byte address
		logic [DATA_WIDTH-1:0] wdata;	// Right-aligned store data
		lsu_op_t cmd;					// One-cycle pulse when not idle
		logic rnw;						// 1 for read
	} lsu_req_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] rdata;	// Load data shifted down to bit 0
		logic busy;						// High from the command until completion
		logic err_align;				// Pulses in the command cycle of a misaligned access
		logic err_bus;					// Pulses in the completion cycle of a failed transfer
	} lsu_rsp_t;

	typedef struct packed {
		logic awvalid;
		logic [DATA_WIDTH-1:0] awaddr;
		logic wvalid;
		logic [DATA_WIDTH-1:0] wdata;
		logic [DATA_WIDTH/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [DATA_WIDTH-1:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [DATA_WIDTH-1:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire
